//--- logic/arp_pkg.sv
package arp_pkg;

  // ============================================================
  // Address types
  // ============================================================

  typedef logic [47:0] mac_t;   // Ethernet hardware address.
  typedef logic [31:0] ipv4_t;  // IPv4 protocol address.

  // ============================================================
  // Opcodes and FSM states
  // ============================================================

  // ARP operation field, carried on the wire as 16 bits.
  typedef enum logic [15:0] {
    arp_request = 16'd1,
    arp_reply   = 16'd2
  } arp_oper_t;

  // Receive FSM. rx_drain swallows bytes beyond the ARP body.
  typedef enum logic [1:0] {
    rx_idle,
    rx_data,
    rx_drain
  } rx_state_t;

  typedef enum logic {
    tx_idle,
    tx_send
  } tx_state_t;

  // ============================================================
  // Addresses of this device
  // ============================================================

  localparam mac_t  own_mac   = 48'h02_00_5e_10_20_30;      // Locally administered.
  localparam ipv4_t own_ip    = {8'd192, 8'd168, 8'd1, 8'd100};
  localparam mac_t  bcast_mac = 48'hffff_ffff_ffff;

  // Fixed protocol values of an Ethernet/IPv4 ARP packet.
  localparam logic [15:0] ethertype_arp  = 16'h0806;
  localparam logic [15:0] htype_ethernet = 16'h0001;
  localparam logic [15:0] ptype_ipv4     = 16'h0800;
  localparam logic [7:0]  arp_hlen       = 8'd6;   // MAC is six bytes.
  localparam logic [7:0]  arp_plen       = 8'd4;   // IPv4 is four bytes.

  // ============================================================
  // Frame geometry
  // ============================================================

  localparam int arp_frame_len = 42;  // 14 byte MAC header plus 28 byte ARP body.
  localparam int min_frame_len = 60;  // Shortest legal Ethernet frame without FCS.

  // Byte offsets of the fields, counted from the first destination MAC byte.
  localparam int off_src  = 6;   // Source MAC.
  localparam int off_type = 12;  // Ethertype, then htype, ptype, hlen, plen.
  localparam int off_oper = 20;  // ARP opcode.
  localparam int off_sha  = 22;  // Sender hardware address.
  localparam int off_spa  = 28;  // Sender protocol address.
  localparam int off_tha  = 32;  // Target hardware address.
  localparam int off_tpa  = 38;  // Target protocol address.

endpackage

//--- logic/frame_rx.sv
`timescale 1ns/1ps

module frame_rx (
  input  logic           clk_rx,
  input  logic           rst_rx,
  input  logic [7:0]     in_d,
  input  logic           in_v,
  output logic           req_valid,
  output arp_pkg::mac_t  peer_mac,
  output arp_pkg::ipv4_t peer_ip,
  output arp_pkg::ipv4_t target_ip
);

  import arp_pkg::*;

  rx_state_t   state;
  logic [10:0] byte_cnt;      // Position of the byte now on in_d.
  logic        dst_bcast_ok;  // Destination MAC so far equals broadcast.
  logic        dst_own_ok;    // Destination MAC so far equals own_mac.
  logic        hdr_ok;        // Ethertype, htype, ptype, hlen and plen match.
  logic        oper_ok;       // Opcode matches arp_request.

  // Returns byte pos of a MAC address, most significant byte first.
  function automatic logic [7:0] mac_byte(input mac_t m, input logic [10:0] pos);
    mac_t s;
    s = m << (8 * pos);
    return s[47:40];
  endfunction

  // Expected value of one of the fixed bytes from off_type up to off_sha.
  function automatic logic [7:0] fixed_byte(input logic [10:0] pos);
    logic [79:0] f;
    f = {ethertype_arp, htype_ethernet, ptype_ipv4, arp_hlen, arp_plen, arp_request};
    f = f << (8 * (pos - off_type));
    return f[79:72];
  endfunction

  // ============================================================
  // Frame FSM and byte counter
  // ============================================================

  always_ff @(posedge clk_rx) begin
    if (rst_rx) begin
      state     <= rx_idle;
      byte_cnt  <= '0;
      req_valid <= 1'b0;
    end else begin
      req_valid <= 1'b0;  // Single cycle pulse by default.
      case (state)
        rx_idle: begin
          if (in_v) begin  // Byte 0 is on the link.
            state    <= rx_data;
            byte_cnt <= 11'd1;
          end
        end
        rx_data: begin
          if (in_v) begin
            byte_cnt <= byte_cnt + 11'd1;
            if (byte_cnt == 11'(arp_frame_len - 1)) state <= rx_drain;  // ARP body done.
          end else begin
            // Frame ended before the ARP body was complete, so it is dropped.
            state    <= rx_idle;
            byte_cnt <= '0;
          end
        end
        rx_drain: begin
          if (in_v) begin
            if (byte_cnt != '1) byte_cnt <= byte_cnt + 11'd1;  // Count padding, saturating.
          end else begin
            req_valid <= (dst_bcast_ok | dst_own_ok) & hdr_ok & oper_ok;
            state     <= rx_idle;
            byte_cnt  <= '0;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // ============================================================
  // Check flags, updated byte by byte
  // ============================================================

  always_ff @(posedge clk_rx) begin
    if (rst_rx) begin
      dst_bcast_ok <= 1'b0;
      dst_own_ok   <= 1'b0;
      hdr_ok       <= 1'b0;
      oper_ok      <= 1'b0;
    end else if (in_v && state != rx_drain) begin
      if (state == rx_idle) begin
        // The first byte starts a fresh set of checks.
        dst_bcast_ok <= (in_d == mac_byte(bcast_mac, byte_cnt));
        dst_own_ok   <= (in_d == mac_byte(own_mac, byte_cnt));
        hdr_ok       <= 1'b1;
        oper_ok      <= 1'b1;
      end else if (byte_cnt < off_src) begin
        dst_bcast_ok <= dst_bcast_ok & (in_d == mac_byte(bcast_mac, byte_cnt));
        dst_own_ok   <= dst_own_ok & (in_d == mac_byte(own_mac, byte_cnt));
      end else if (byte_cnt inside {[off_type:off_oper-1]}) begin
        hdr_ok <= hdr_ok & (in_d == fixed_byte(byte_cnt));
      end else if (byte_cnt inside {[off_oper:off_sha-1]}) begin
        oper_ok <= oper_ok & (in_d == fixed_byte(byte_cnt));
      end
      // The source MAC and the target MAC are not checked.
    end
  end

  // ============================================================
  // Address capture
  // ============================================================

  // Fields shift in MSB first; they hold until the next frame reaches them.
  always_ff @(posedge clk_rx) begin
    if (in_v && state == rx_data) begin
      if (byte_cnt inside {[off_sha:off_spa-1]}) peer_mac <= {peer_mac[39:0], in_d};
      if (byte_cnt inside {[off_spa:off_tha-1]}) peer_ip <= {peer_ip[23:0], in_d};
      if (byte_cnt inside {[off_tpa:arp_frame_len-1]}) begin
        target_ip <= {target_ip[23:0], in_d};  // Compared with own_ip downstream.
      end
    end
  end

endmodule

//--- logic/arp_responder.sv
`timescale 1ns/1ps

module arp_responder (
  input  logic           clk_rx,
  input  logic           rst_rx,
  input  logic           req_valid,
  input  arp_pkg::mac_t  peer_mac,
  input  arp_pkg::ipv4_t peer_ip,
  input  arp_pkg::ipv4_t target_ip,
  input  logic           tx_busy,
  output logic           tx_start,
  output arp_pkg::mac_t  reply_mac,
  output arp_pkg::ipv4_t reply_ip
);

  import arp_pkg::*;

  // ============================================================
  // Request decision
  // ============================================================

  logic        for_us;        // The request asks for our IPv4 address.
  logic        accept;        // Reply can start on the next cycle.

  assign for_us = req_valid & (target_ip == own_ip);
  assign accept = for_us & ~tx_busy;  // There is no queue, so busy requests are lost.

  // ============================================================
  // Start pulse
  // ============================================================

  always_ff @(posedge clk_rx) begin
    if (rst_rx) begin
      tx_start <= 1'b0;
    end else begin
      tx_start <= accept;  // One cycle behind req_valid.
    end
  end

  // ============================================================
  // Peer address hold
  // ============================================================

  // Loaded only on acceptance. While a reply is going out, tx_busy blocks
  // acceptance, so a later frame cannot disturb the bytes in flight.
  always_ff @(posedge clk_rx) begin
    if (accept) begin
      reply_mac <= peer_mac;
      reply_ip  <= peer_ip;
    end
  end

endmodule

//--- logic/frame_tx.sv
`timescale 1ns/1ps

module frame_tx (
  input  logic           clk_rx,
  input  logic           rst_rx,
  input  logic           tx_start,
  input  arp_pkg::mac_t  reply_mac,
  input  arp_pkg::ipv4_t reply_ip,
  output logic           tx_busy,
  output logic [7:0]     out_d,
  output logic           out_v
);

  import arp_pkg::*;

  tx_state_t                  state;
  logic [5:0]                 byte_idx;     // Index of the next byte to register.
  logic [8*arp_frame_len-1:0] reply_vec;    // Whole reply body, first byte on top.
  logic [8*arp_frame_len-1:0] reply_shift;
  logic [7:0]                 next_byte;

  // ============================================================
  // Reply contents
  // ============================================================

  always_comb begin
    reply_vec = {
      reply_mac,                     // Destination is the requester.
      own_mac,                       // Source.
      ethertype_arp,
      htype_ethernet,
      ptype_ipv4,
      arp_hlen,
      arp_plen,
      arp_reply,
      own_mac, own_ip,               // Sender fields.
      reply_mac, reply_ip            // Target fields.
    };
  end

  // byte_idx rests at zero while idle, so byte 0 is ready on the start edge.
  always_comb begin
    reply_shift = reply_vec << (8 * byte_idx);
    if (byte_idx < 6'(arp_frame_len)) begin
      next_byte = reply_shift[8*arp_frame_len-1 -: 8];
    end else begin
      next_byte = 8'h00;  // Padding up to min_frame_len.
    end
  end

  // ============================================================
  // Transmit FSM
  // ============================================================

  always_ff @(posedge clk_rx) begin
    if (rst_rx) begin
      state    <= tx_idle;
      byte_idx <= '0;
      out_v    <= 1'b0;
      out_d    <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (tx_start) begin
            state    <= tx_send;
            out_v    <= 1'b1;
            out_d    <= next_byte;
            byte_idx <= 6'd1;
          end
        end
        tx_send: begin
          if (byte_idx == 6'(min_frame_len)) begin
            // Byte 59 has been on the link for its cycle.
            state    <= tx_idle;
            out_v    <= 1'b0;
            out_d    <= '0;
            byte_idx <= '0;
          end else begin
            out_d    <= next_byte;
            byte_idx <= byte_idx + 6'd1;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // Busy from the start pulse through the cycle that carries the last byte.
  assign tx_busy = tx_start | (state == tx_send);

endmodule

//--- logic/arp_device.sv
`timescale 1ns/1ps

module arp_device (
  input  logic       clk_rx,
  input  logic       rst_rx,
  input  logic [7:0] in_d,
  input  logic       in_v,
  output logic [7:0] out_d,
  output logic       out_v
);

  import arp_pkg::*;

  // ============================================================
  // Internal links
  // ============================================================

  logic  req_valid;  // Decoded request, one cycle after the frame ends.
  mac_t  peer_mac;
  ipv4_t peer_ip;
  ipv4_t target_ip;
  logic  tx_start;   // Reply accepted.
  mac_t  reply_mac;
  ipv4_t reply_ip;
  logic  tx_busy;

  frame_rx u_frame_rx (
    .clk_rx    (clk_rx),
    .rst_rx    (rst_rx),
    .in_d      (in_d),
    .in_v      (in_v),
    .req_valid (req_valid),
    .peer_mac  (peer_mac),
    .peer_ip   (peer_ip),
    .target_ip (target_ip)
  );

  arp_responder u_arp_responder (
    .clk_rx    (clk_rx),
    .rst_rx    (rst_rx),
    .req_valid (req_valid),
    .peer_mac  (peer_mac),
    .peer_ip   (peer_ip),
    .target_ip (target_ip),
    .tx_busy   (tx_busy),
    .tx_start  (tx_start),
    .reply_mac (reply_mac),
    .reply_ip  (reply_ip)
  );

  // Three cycles from the end of a request to the first reply byte.
  frame_tx u_frame_tx (
    .clk_rx    (clk_rx),
    .rst_rx    (rst_rx),
    .tx_start  (tx_start),
    .reply_mac (reply_mac),
    .reply_ip  (reply_ip),
    .tx_busy   (tx_busy),
    .out_d     (out_d),
    .out_v     (out_v)
  );

endmodule

//--- tb/tb_arp_device.sv
`timescale 1ns/1ps

module tb_arp_device;

  import arp_pkg::*;

  // ============================================================
  // Run geometry and frame kinds
  // ============================================================

  localparam int clk_period = 100;
  localparam int num_tests  = 48;
  localparam int max_gap    = 100;  // Longest idle gap, counting the first low cycle.
  localparam int watchdog_cycles = 5 + num_tests * (min_frame_len + max_gap) + 200;

  localparam int k_bcast      = 0;   // Valid request, broadcast destination.
  localparam int k_unicast    = 1;   // Valid request, sent to own_mac.
  localparam int k_wrong_tip  = 2;
  localparam int k_bad_type   = 3;
  localparam int k_bad_htype  = 4;
  localparam int k_bad_ptype  = 5;
  localparam int k_bad_hlen   = 6;
  localparam int k_bad_plen   = 7;
  localparam int k_short      = 8;   // Cut off before the ARP body is complete.
  localparam int k_bad_dst    = 9;
  localparam int k_oper_reply = 10;
  localparam int num_kinds    = 11;

  logic       clk_rx;
  logic       rst_rx;
  logic [7:0] in_d;
  logic       in_v;
  logic [7:0] out_d;
  logic       out_v;

  int         cyc;                       // Index of the current clock cycle.
  logic [7:0] frame_bytes[$];            // Frame that the driver sends next.
  logic [7:0] got[$];                    // Bytes of the reply now on out_d.
  int         reply_start;               // Cycle of the first byte in got.
  int         pending[$];                // Tests whose reply is still due, in order.
  int         last_accept = -1000;       // Frame end of the last reply the model started.
  int         sent_count  = 0;
  int         reported    = 0;
  int         errors      = 0;
  string      test_name[num_tests];
  int         end_cyc[num_tests];        // First low cycle of in_v after the frame.
  int         test_err[num_tests];
  bit         expect_reply[num_tests];
  bit         got_reply[num_tests];
  mac_t       exp_mac[num_tests];
  ipv4_t      exp_ip[num_tests];

  arp_device u_arp_device (
    .clk_rx (clk_rx),
    .rst_rx (rst_rx),
    .in_d   (in_d),
    .in_v   (in_v),
    .out_d  (out_d),
    .out_v  (out_v)
  );

  // The cycle count moves before the rising edge, so every process sees it settled.
  initial begin
    clk_rx = 1'b0;
    cyc    = 0;
    forever begin
      #(clk_period / 2);
      cyc    = cyc + 1;
      clk_rx = 1'b1;
      #(clk_period / 2);
      clk_rx = 1'b0;
    end
  end

  // ============================================================
  // Compare tasks
  // ============================================================

  task automatic note_error(input int id);
    test_err[id]++;
    errors++;
  endtask

  task automatic check_mac(input int id, input string what, input mac_t exp, input mac_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s, %s: expected %012h, actual %012h", test_name[id], what, exp, act);
      note_error(id);
    end
  endtask

  task automatic check_ipv4(input int id, input string what, input ipv4_t exp, input ipv4_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s, %s: expected %08h, actual %08h", test_name[id], what, exp, act);
      note_error(id);
    end
  endtask

  task automatic check_oper(input int id, input string what, input arp_oper_t exp,
                            input arp_oper_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s, %s: expected %0d, actual %0d", test_name[id], what, exp, act);
      note_error(id);
    end
  endtask

  task automatic check_len(input int id, input string what, input int exp, input int act);
    if (exp != act) begin
      $display("CHECK FAILED %s, %s: expected %0d, actual %0d", test_name[id], what, exp, act);
      note_error(id);
    end
  endtask

  task automatic check_byte(input int id, input string what, input logic [7:0] exp,
                            input logic [7:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s, %s: expected %02h, actual %02h", test_name[id], what, exp, act);
      note_error(id);
    end
  endtask

  // ============================================================
  // Stimulus
  // ============================================================

  function automatic string kind_name(input int kind);
    case (kind)
      k_bcast:      return "broadcast request";
      k_unicast:    return "unicast request";
      k_wrong_tip:  return "other target IP";
      k_bad_type:   return "non-ARP ethertype";
      k_bad_htype:  return "wrong htype";
      k_bad_ptype:  return "wrong ptype";
      k_bad_hlen:   return "wrong hlen";
      k_bad_plen:   return "wrong plen";
      k_short:      return "short frame";
      k_bad_dst:    return "foreign destination MAC";
      default:      return "ARP reply opcode";
    endcase
  endfunction

  // Every kind once, then a valid pair whose second half lands in the busy window.
  function automatic int pick_kind(input int id);
    if (id < num_kinds) return id;
    if (id == num_kinds) return k_bcast;
    if (id == num_kinds + 1) return k_unicast;
    if ($urandom % 2) return $urandom % 2;  // Half of the rest are valid requests.
    return $urandom % num_kinds;
  endfunction

  function automatic int pick_gap(input int id);
    if (id < num_kinds) return 80;
    if (id == num_kinds) return 1;  // Next request ends while this reply is on the link.
    if ($urandom % 3 == 0) return 1 + $urandom % 8;
    return 64 + $urandom % 36;
  endfunction

  task automatic build_frame(input int kind, input mac_t pmac, input ipv4_t pip, input int pad);
    mac_t                       dst;
    logic [15:0]                etype;
    logic [15:0]                htype;
    logic [15:0]                ptype;
    logic [7:0]                 hlen;
    logic [7:0]                 plen;
    arp_oper_t                  oper;
    ipv4_t                      tpa;
    logic [31:0]                r;
    logic [8*arp_frame_len-1:0] body;
    int                         len;
    r     = $urandom;
    dst   = (kind == k_unicast) ? own_mac : bcast_mac;
    etype = ethertype_arp;
    htype = htype_ethernet;
    ptype = ptype_ipv4;
    hlen  = 8'd6;
    plen  = 8'd4;
    oper  = arp_request;
    tpa   = own_ip;
    len   = arp_frame_len + pad;  // Padding bytes are random and must be ignored.
    case (kind)
      k_wrong_tip:  tpa   = own_ip ^ (32'd1 << r[4:0]);  // One bit off.
      k_bad_type:   etype = 16'h0800;                    // IPv4 instead of ARP.
      k_bad_htype:  htype = 16'h0006;
      k_bad_ptype:  ptype = 16'h86dd;
      k_bad_hlen:   hlen  = 8'd8;
      k_bad_plen:   plen  = 8'd16;
      k_short:      len   = 1 + r % (arp_frame_len - 1);
      k_bad_dst:    dst   = {8'h0a, r, 8'h5c};           // Neither broadcast nor own_mac.
      k_oper_reply: oper  = arp_reply;
      default: ;
    endcase
    // Ethernet header, then the ARP body with a zero target MAC.
    body = {dst, pmac, etype, htype, ptype, hlen, plen, oper, pmac, pip, 48'h0, tpa};
    frame_bytes.delete();
    for (int i = 0; i < len; i++) begin
      if (i < arp_frame_len) frame_bytes.push_back(body[8*(arp_frame_len-1-i) +: 8]);
      else frame_bytes.push_back(8'($urandom));
    end
  endtask

  // Sends frame_bytes back to back and returns the first low cycle of in_v.
  task automatic send_frame(output int end_c);
    foreach (frame_bytes[i]) begin
      @(posedge clk_rx);
      in_d <= frame_bytes[i];
      in_v <= 1'b1;
    end
    @(posedge clk_rx);
    in_v  <= 1'b0;
    in_d  <= 8'h00;
    end_c = cyc;
  endtask

  // ============================================================
  // Reference model
  // ============================================================

  // A reply holds tx_busy from end+2 to end+62, and a later request is looked at
  // in the cycle after its own end. So it is accepted only 62 cycles on or later.
  task automatic model_request(input int id, input int kind, input int end_c,
                               input mac_t pmac, input ipv4_t pip);
    expect_reply[id] = 1'b0;
    if (kind == k_bcast || kind == k_unicast) begin
      if (end_c - last_accept >= min_frame_len + 2) begin
        expect_reply[id] = 1'b1;
        exp_mac[id]      = pmac;
        exp_ip[id]       = pip;
        last_accept      = end_c;
        pending.push_back(id);
      end else begin
        test_name[id] = {test_name[id], " (dropped, busy)"};
      end
    end
  endtask

  function automatic mac_t take_mac(input int pos);
    mac_t m;
    for (int i = 0; i < 6; i++) m = {m[39:0], got[pos + i]};
    return m;
  endfunction

  function automatic ipv4_t take_ip(input int pos);
    return {got[pos], got[pos + 1], got[pos + 2], got[pos + 3]};
  endfunction

  task automatic check_reply();
    int          id;
    logic [63:0] hdr;
    hdr = {ethertype_arp, htype_ethernet, ptype_ipv4, 8'd6, 8'd4};
    if (pending.size() == 0) begin
      $display("Reply of %0d bytes at cycle %0d answers no pending request",
               got.size(), reply_start);
      errors++;
      return;
    end
    id = pending.pop_front();
    got_reply[id] = 1'b1;
    check_len(id, "first byte cycle", end_cyc[id] + 3, reply_start);
    check_len(id, "reply length", min_frame_len, got.size());
    if (got.size() < min_frame_len) return;  // Field offsets would run past the end.
    check_mac(id, "destination MAC", exp_mac[id], take_mac(0));
    check_mac(id, "source MAC", own_mac, take_mac(6));
    for (int i = 0; i < 8; i++) check_byte(id, "header byte", hdr[63-8*i -: 8], got[12 + i]);
    check_oper(id, "opcode", arp_reply, arp_oper_t'({got[20], got[21]}));
    check_mac(id, "sender MAC", own_mac, take_mac(22));
    check_ipv4(id, "sender IP", own_ip, take_ip(28));
    check_mac(id, "target MAC", exp_mac[id], take_mac(32));
    check_ipv4(id, "target IP", exp_ip[id], take_ip(38));
    for (int i = arp_frame_len; i < min_frame_len; i++) check_byte(id, "padding", 8'h00, got[i]);
  endtask

  // Outputs change on the rising edge and are sampled on the falling one.
  always @(negedge clk_rx) begin
    if (!rst_rx) begin
      if (out_v) begin
        if (got.size() == 0) reply_start = cyc;
        got.push_back(out_d);
      end else if (got.size() != 0) begin
        check_reply();
        got.delete();
      end
    end
  end

  // A test is over once its possible reply would have left the link.
  initial begin : reporter
    for (int id = 0; id < num_tests; id++) begin
      while (sent_count <= id) @(negedge clk_rx);
      while (cyc < end_cyc[id] + min_frame_len + 4) @(negedge clk_rx);
      if (expect_reply[id] && !got_reply[id]) begin
        $display("%s: the expected reply never appeared on out_v", test_name[id]);
        note_error(id);
      end
      $display("%s: %s", test_name[id], (test_err[id] == 0) ? "ok" : "FAILED");
      reported++;
    end
  end

  // ============================================================
  // Main sequence and watchdog
  // ============================================================

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired at cycle %0d before all tests completed", cyc);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int          kind;
    int          gap;
    int          pad;
    int          end_c;
    int          passed;
    logic [31:0] r1;
    logic [31:0] r2;
    mac_t        pmac;
    ipv4_t       pip;
    void'($urandom(32'h334c));
    rst_rx = 1'b1;
    in_d   = 8'h00;
    in_v   = 1'b0;
    repeat (5) @(posedge clk_rx);
    rst_rx <= 1'b0;
    @(negedge clk_rx);
    if (out_v !== 1'b0 || out_d !== 8'h00) begin
      $display("The transmit link is not idle after reset");
      errors++;
    end
    for (int id = 0; id < num_tests; id++) begin
      kind = pick_kind(id);
      gap  = pick_gap(id);
      r1   = $urandom;
      r2   = $urandom;
      pmac = {r1[15:0], r2};
      pip  = $urandom;
      pad  = $urandom % (min_frame_len - arp_frame_len + 1);
      test_name[id] = $sformatf("test %0d %s", id, kind_name(kind));
      build_frame(kind, pmac, pip, pad);
      send_frame(end_c);
      end_cyc[id] = end_c;
      model_request(id, kind, end_c, pmac, pip);
      sent_count = id + 1;
      repeat (gap - 1) @(posedge clk_rx);
    end
    while (reported < num_tests) @(negedge clk_rx);
    if (pending.size() != 0) begin
      $display("%0d expected replies were still outstanding at the end", pending.size());
      errors++;
    end
    passed = 0;
    foreach (test_err[i]) if (test_err[i] == 0) passed++;
    $display("Tests: %0d, passed: %0d, failed: %0d, errors: %0d",
             num_tests, passed, num_tests - passed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
logic/arp_pkg.sv
logic/frame_rx.sv
logic/arp_responder.sv
logic/frame_tx.sv
logic/arp_device.sv
tb/tb_arp_device.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_arp_device
FILELIST := verilog.f
OBJ_DIR  := obj_dir

SOURCES  := $(shell cat $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulator output.
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
